//--- bender.yml
package:
  name: i2si

sources:
  - logic/i2si_pkg.sv
  - logic/i2si_sck_sync.sv
  - logic/i2si_deserializer.sv
  - logic/i2si_bist_gen.sv
  - logic/i2si_ctrl.sv
  - logic/i2si_top.sv
  - target: simulation
    files:
      - tb/i2si_chk.sv
      - tb/i2si_tb.sv

//--- logic/i2si_bist_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Saw-tooth source, one sample per BIST_DIV serial clock pulses
module i2si_bist_gen import i2si_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sck_rise,
    input  i2si_mode_e        mode,
    input  logic [BIST_W-1:0] bist_start,
    input  logic [INC_W-1:0]  bist_inc,
    input  logic [BIST_W-1:0] bist_limit,
    output logic              bist_valid,
    output logic              bist_wrap,
    output logic [DATA_W-1:0] bist_data
);

    logic [BIST_CNT_W-1:0] sck_cnt;
    logic                  started;
    logic                  sample;

    assign sample = sck_rise && (sck_cnt == BIST_CNT_W'(BIST_DIV - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_cnt    <= '0;
            started    <= 1'b0;
            bist_valid <= 1'b0;
            bist_wrap  <= 1'b0;
            bist_data  <= '0;
        end
        else if (mode != MODE_BIST)
        begin
            sck_cnt    <= '0;      // Restart the sequence on re-entry
            started    <= 1'b0;
            bist_valid <= 1'b0;
            bist_wrap  <= 1'b0;
        end
        else
        begin
            bist_valid <= sample;
            if (sck_rise)
                sck_cnt <= sck_cnt + 1'b1;    // Wraps at BIST_DIV
            if (sample)
            begin
                started <= 1'b1;
                if (!started || bist_data >= DATA_W'(bist_limit))
                begin
                    bist_data <= DATA_W'(bist_start);
                    bist_wrap <= 1'b1;
                end
                else
                begin
                    bist_data <= bist_data + DATA_W'(bist_inc);
                    bist_wrap <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/i2si_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_ctrl import i2si_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              reg_we,
    input  i2si_addr_e        reg_addr,
    input  logic [REG_W-1:0]  reg_wdata,
    input  logic              rx_valid,
    input  logic [DATA_W-1:0] rx_data,
    input  logic              rx_channel,
    input  logic              bist_valid,
    input  logic [DATA_W-1:0] bist_data,
    input  logic              bist_wrap,
    output i2si_mode_e        mode,
    output logic [BIST_W-1:0] bist_start,
    output logic [INC_W-1:0]  bist_inc,
    output logic [BIST_W-1:0] bist_limit,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              out_channel,
    output logic              out_wrap
);

    logic sel_rx;
    logic sel_bist;
    logic bist_chan;    // Alternating channel for BIST words

    assign sel_rx   = (mode == MODE_RX) && rx_valid;
    assign sel_bist = (mode == MODE_BIST) && bist_valid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mode        <= MODE_OFF;
            bist_start  <= BIST_START_RST;
            bist_inc    <= BIST_INC_RST;
            bist_limit  <= BIST_LIMIT_RST;
            bist_chan   <= 1'b0;
            out_valid   <= 1'b0;
            out_channel <= 1'b0;
            out_wrap    <= 1'b0;
        end
        else
        begin
            if (reg_we)
            begin
                case (reg_addr)
                    ADDR_MODE:
                    begin
                        case (reg_wdata[1:0])
                            2'd1:    mode <= MODE_RX;
                            2'd2:    mode <= MODE_BIST;
                            default: mode <= MODE_OFF;    // Unused code turns it off
                        endcase
                    end
                    ADDR_START: bist_start <= reg_wdata[BIST_W-1:0];
                    ADDR_INC:   bist_inc   <= reg_wdata[INC_W-1:0];
                    ADDR_LIMIT: bist_limit <= reg_wdata[BIST_W-1:0];
                    default:    ;
                endcase
            end
            out_valid <= sel_rx || sel_bist;
            if (mode != MODE_BIST)
                bist_chan <= 1'b0;
            else if (bist_valid)
                bist_chan <= ~bist_chan;
            if (sel_rx)
            begin
                out_channel <= rx_channel;
                out_wrap    <= 1'b0;
            end
            else if (sel_bist)
            begin
                out_channel <= bist_chan;
                out_wrap    <= bist_wrap;
            end
        end
    end

    // Output word register
    always_ff @(posedge clk)
    begin
        if (sel_rx)
            out_data <= rx_data;
        else if (sel_bist)
            out_data <= bist_data;
    end

endmodule

`default_nettype wire

//--- logic/i2si_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_deserializer import i2si_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sck_rise,
    input  logic              ws_s,
    input  logic              sd_s,
    output logic              rx_valid,
    output logic [DATA_W-1:0] rx_data,
    output logic              rx_channel
);

    logic                 ws_prev;
    logic                 active;     // A word is being collected
    logic                 word_ws;    // ws level of the current word
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [DATA_W-1:0]    shreg;
    logic                 shift_en;
    logic                 ws_change;

    // Bits past DATA_W are dropped until the next ws change
    assign shift_en  = sck_rise && active && (bit_cnt < BIT_CNT_W'(DATA_W));
    assign ws_change = sck_rise && (ws_s != ws_prev);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_prev    <= 1'b0;
            active     <= 1'b0;
            word_ws    <= 1'b0;
            bit_cnt    <= '0;
            rx_valid   <= 1'b0;
            rx_channel <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if (sck_rise)
                ws_prev <= ws_s;
            if (shift_en)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_CNT_W'(DATA_W - 1))
                begin
                    rx_valid   <= 1'b1;    // LSB just shifted in
                    rx_channel <= word_ws;
                end
            end
            // The rise that sees the change still carries the old LSB,
            // the MSB of the new word follows on the next rise
            if (ws_change)
            begin
                active  <= 1'b1;
                bit_cnt <= '0;
                word_ws <= ws_s;
            end
        end
    end

    // MSB first
    always_ff @(posedge clk)
    begin
        if (shift_en)
            shreg <= {shreg[DATA_W-2:0], sd_s};
    end

    assign rx_data = shreg;    // Stable for several clk after rx_valid

endmodule

`default_nettype wire

//--- logic/i2si_pkg.sv
`default_nettype none

package i2si_pkg;

    localparam int DATA_W   = 32;    // Received and output word width
    localparam int BIST_W   = 12;    // BIST start value and upper limit
    localparam int INC_W    = 8;     // BIST increment
    localparam int BIST_DIV = 16;    // sck rising pulses per BIST sample
    localparam int REG_W    = 16;    // Register write data

    // Counter widths derived from the above
    localparam int BIT_CNT_W  = $clog2(DATA_W + 1);
    localparam int BIST_CNT_W = $clog2(BIST_DIV);

    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_RX   = 2'd1,
        MODE_BIST = 2'd2
    } i2si_mode_e;

    typedef enum logic [1:0] {
        ADDR_MODE  = 2'd0,
        ADDR_START = 2'd1,
        ADDR_INC   = 2'd2,
        ADDR_LIMIT = 2'd3
    } i2si_addr_e;

    // Configuration register reset values
    localparam logic [BIST_W-1:0] BIST_START_RST = 12'd0;
    localparam logic [INC_W-1:0]  BIST_INC_RST   = 8'd1;
    localparam logic [BIST_W-1:0] BIST_LIMIT_RST = 12'hFFF;

endpackage

`default_nettype wire

//--- logic/i2si_sck_sync.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_sck_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic i2s_sck,
    input  logic i2s_ws,
    input  logic i2s_sd,
    output logic sck_rise,
    output logic ws_s,
    output logic sd_s
);

    logic [2:0] pin_meta;    // First stage, {sck, ws, sd}
    logic [2:0] pin_sync;    // Second stage
    logic       sck_prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pin_meta <= '0;
            pin_sync <= '0;
            sck_prev <= 1'b0;
            sck_rise <= 1'b0;
            ws_s     <= 1'b0;
            sd_s     <= 1'b0;
        end
        else
        begin
            pin_meta <= {i2s_sck, i2s_ws, i2s_sd};
            pin_sync <= pin_meta;
            sck_prev <= pin_sync[2];
            // Edge register, pulse lasts one clk
            sck_rise <= pin_sync[2] & ~sck_prev;
            // Data copies aligned with the pulse
            ws_s     <= pin_sync[1];
            sd_s     <= pin_sync[0];
        end
    end

endmodule

`default_nettype wire

//--- logic/i2si_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_top import i2si_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i2s_sck,
    input  logic              i2s_ws,
    input  logic              i2s_sd,
    input  logic              reg_we,
    input  i2si_addr_e        reg_addr,
    input  logic [REG_W-1:0]  reg_wdata,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              out_channel,
    output logic              out_wrap
);

    // Synchronized pin side
    logic              sck_rise;
    logic              ws_s;
    logic              sd_s;

    logic              rx_valid;
    logic [DATA_W-1:0] rx_data;
    logic              rx_channel;

    logic              bist_valid;
    logic [DATA_W-1:0] bist_data;
    logic              bist_wrap;

    // Configuration to the generator
    i2si_mode_e        mode;
    logic [BIST_W-1:0] bist_start;
    logic [INC_W-1:0]  bist_inc;
    logic [BIST_W-1:0] bist_limit;

    i2si_sck_sync sync_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i2s_sck  (i2s_sck),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    i2si_deserializer deser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck_rise   (sck_rise),
        .ws_s       (ws_s),
        .sd_s       (sd_s),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_channel (rx_channel)
    );

    i2si_bist_gen bist_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck_rise   (sck_rise),
        .mode       (mode),
        .bist_start (bist_start),
        .bist_inc   (bist_inc),
        .bist_limit (bist_limit),
        .bist_valid (bist_valid),
        .bist_wrap  (bist_wrap),
        .bist_data  (bist_data)
    );

    i2si_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_channel  (rx_channel),
        .bist_valid  (bist_valid),
        .bist_data   (bist_data),
        .bist_wrap   (bist_wrap),
        .mode        (mode),
        .bist_start  (bist_start),
        .bist_inc    (bist_inc),
        .bist_limit  (bist_limit),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_wrap    (out_wrap)
    );

endmodule

`default_nettype wire

//--- tb.f
logic/i2si_pkg.sv
logic/i2si_sck_sync.sv
logic/i2si_deserializer.sv
logic/i2si_bist_gen.sv
logic/i2si_ctrl.sv
logic/i2si_top.sv
tb/i2si_chk.sv
tb/i2si_tb.sv

//--- tb/i2si_chk.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_chk import i2si_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input i2si_mode_e mode,
    input logic       out_valid,
    input logic       out_wrap
);

    int fail_cnt = 0;    // Read by the testbench at the end

    // Output strobe lasts one cycle
    single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else
    begin
        fail_cnt++;
        $error("out_valid high on two consecutive cycles");
    end

    // Mode is registered one cycle before the strobe
    off_silent: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == MODE_OFF) |=> !out_valid)
    else
    begin
        fail_cnt++;
        $error("out_valid high while the mode is off");
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!out_valid && !out_wrap))
    else
    begin
        fail_cnt++;
        $error("out_valid or out_wrap high during reset");
    end

endmodule

`default_nettype wire

//--- tb/i2si_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i2si_tb import i2si_pkg::*; ();

    logic              clk;
    logic              rst_n;
    logic              i2s_sck;
    logic              i2s_ws;
    logic              i2s_sd;
    logic              reg_we;
    i2si_addr_e        reg_addr;
    logic [REG_W-1:0]  reg_wdata;
    logic              out_valid;
    logic [DATA_W-1:0] out_data;
    logic              out_channel;
    logic              out_wrap;

    int                seed;
    int                errors;
    logic              ws_level;    // Current ws level on the pin
    logic [DATA_W-1:0] exp_data_q[$];
    logic              exp_ch_q[$];
    logic [DATA_W-1:0] got_data_q[$];
    logic              got_ch_q[$];
    logic              got_wrap_q[$];

    i2si_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i2s_sck     (i2s_sck),
        .i2s_ws      (i2s_ws),
        .i2s_sd      (i2s_sd),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_wrap    (out_wrap)
    );

    bind i2si_top i2si_chk chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .out_valid (out_valid),
        .out_wrap  (out_wrap)
    );

    always #20 clk = ~clk;

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst_n && out_valid)
        begin
            got_data_q.push_back(out_data);
            got_ch_q.push_back(out_channel);
            got_wrap_q.push_back(out_wrap);
        end
    end

    task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got=%h exp=%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_queues();
        exp_data_q.delete();
        exp_ch_q.delete();
        got_data_q.delete();
        got_ch_q.delete();
        got_wrap_q.delete();
    endtask

    task automatic write_reg(input i2si_addr_e addr, input logic [REG_W-1:0] data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_we    <= 1'b0;
    endtask

    // One serial clock period of 4 clk low and 4 clk high
    task automatic drive_bit(input logic ws, input logic sd);
        @(posedge clk);
        i2s_sck <= 1'b0;    // Transmitter changes on the falling edge
        i2s_ws  <= ws;
        i2s_sd  <= sd;
        repeat (4) @(posedge clk);
        i2s_sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // Random words with one per ws half and the MSB one period after the ws change
    task automatic send_words(input int n, input int half_len);
        logic [DATA_W-1:0] words[$];
        logic [DATA_W-1:0] w;
        int                filler;
        int                len;
        int                j;
        int                k;
        int                p;
        for (k = 0; k < n; k++)
            words.push_back($random(seed));
        // Extra short half at the end carries the last delayed bit
        for (k = 0; k <= n; k++)
        begin
            ws_level = ~ws_level;
            if (k < n)
            begin
                exp_data_q.push_back(words[k]);
                exp_ch_q.push_back(ws_level);
            end
            len = (k < n) ? half_len : 2;
            for (p = 0; p < len; p++)
            begin
                filler = $random(seed);
                if (p == 0)
                begin
                    w = (k > 0) ? words[k-1] : '0;
                    j = half_len - 1;
                end
                else
                begin
                    w = (k < n) ? words[k] : '0;
                    j = p - 1;
                end
                drive_bit(ws_level, (j < DATA_W) ? w[DATA_W-1-j] : filler[0]);
            end
        end
    endtask

    task automatic wait_words(input int n, input logic run_sck);
        int tries;
        tries = 0;
        while (got_data_q.size() < n && tries < 400)
        begin
            if (run_sck)
                drive_bit(ws_level, 1'b0);
            else
                @(posedge clk);
            tries++;
        end
        if (got_data_q.size() < n)
        begin
            $display("ERROR: timeout, only %0d of %0d output words seen",
                     got_data_q.size(), n);
            errors++;
        end
    endtask

    task automatic check_rx_words(input int n);
        wait_words(n, 1'b0);
        compare_value("out_count", got_data_q.size(), n);
        while (got_data_q.size() > 0 && exp_data_q.size() > 0)
        begin
            compare_value("out_data", got_data_q.pop_front(), exp_data_q.pop_front());
            compare_value("out_channel", got_ch_q.pop_front(), exp_ch_q.pop_front());
            compare_value("out_wrap", got_wrap_q.pop_front(), 0);
        end
    endtask

    // Saw-tooth model from the sample rule
    task automatic run_bist(input int n, input int start, input int inc, input int limit);
        int   val;
        logic wrap;
        int   k;
        val = 0;
        clear_queues();
        write_reg(ADDR_MODE, REG_W'(MODE_BIST));
        wait_words(n, 1'b1);
        write_reg(ADDR_MODE, REG_W'(MODE_OFF));
        compare_value("out_count", got_data_q.size(), n);
        for (k = 0; k < n && got_data_q.size() > 0; k++)
        begin
            if (k == 0 || val >= limit)
            begin
                val  = start;
                wrap = 1'b1;
            end
            else
            begin
                val  = val + inc;
                wrap = 1'b0;
            end
            compare_value("out_data", got_data_q.pop_front(), val);
            compare_value("out_wrap", got_wrap_q.pop_front(), wrap);
            compare_value("out_channel", got_ch_q.pop_front(), k % 2);
        end
    endtask

    task automatic off_mode_silent();
        clear_queues();
        send_words(4, 32);
        repeat (40) @(posedge clk);
        compare_value("out_count", got_data_q.size(), 0);
    endtask

    task automatic rx_words_in_order();
        write_reg(ADDR_MODE, REG_W'(MODE_RX));
        clear_queues();
        send_words(6, 32);
        check_rx_words(6);
    endtask

    task automatic extra_bits_ignored();
        clear_queues();
        send_words(4, 36);    // 4 surplus bits per half
        check_rx_words(4);
    endtask

    task automatic bist_sawtooth();
        write_reg(ADDR_START, 16'd100);
        write_reg(ADDR_INC, 16'd7);
        write_reg(ADDR_LIMIT, 16'd140);
        run_bist(8, 100, 7, 140);    // Ends on the restart value 100
    endtask

    task automatic bist_restart();
        write_reg(ADDR_MODE, REG_W'(MODE_OFF));
        write_reg(ADDR_INC, 16'd1);
        write_reg(ADDR_LIMIT, 16'd102);
        run_bist(4, 100, 1, 102);
    endtask

    initial
    begin
        seed      = 72;
        errors    = 0;
        ws_level  = 1'b0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        i2s_sck   = 1'b0;
        i2s_ws    = 1'b0;
        i2s_sd    = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = ADDR_MODE;
        reg_wdata = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        off_mode_silent();
        rx_words_in_order();
        extra_bits_ignored();
        bist_sawtooth();
        bist_restart();
        repeat (4) @(posedge clk);
        $display("Errors: %0d, assertion failures: %0d", errors, dut_i.chk_i.fail_cnt);
        if (errors == 0 && dut_i.chk_i.fail_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
